/* rtl/rv32_isa_pkg.sv */
// RV32 instruction field types and opcode constants, imported by the decoder and the top level
`default_nettype none

package rv32_isa_pkg;

  // Data and address word
  typedef logic [31:0] word_t;

  // Register index
  typedef logic [4:0] reg_idx_t;

  // Instruction fields
  typedef logic [6:0] opcode_t;
  typedef logic [2:0] funct3_t;
  typedef logic [6:0] funct7_t;

  // Major opcodes handled by the front end
  localparam opcode_t OPC_OP     = 7'b0110011;
  localparam opcode_t OPC_OP_IMM = 7'b0010011;
  localparam opcode_t OPC_LUI    = 7'b0110111;
  localparam opcode_t OPC_AUIPC  = 7'b0010111;
  localparam opcode_t OPC_JAL    = 7'b1101111;
  localparam opcode_t OPC_LOAD   = 7'b0000011;
  localparam opcode_t OPC_STORE  = 7'b0100011;

  // M extension marker on OP
  localparam funct7_t FUNCT7_MULDIV = 7'h01;

  // SUB and SRA/SRAI select
  localparam funct7_t FUNCT7_ALT = 7'h20;

  // Link offset for JAL
  localparam word_t PC_STEP = 32'd4;

endpackage

`default_nettype wire

/* rtl/dispatch_pkg.sv */
// Functional-unit classes, ALU operations and dispatch field types shared by all dispatch RTL
`default_nettype none

package dispatch_pkg;

  // Number of functional-unit classes, one queue each
  localparam int NUM_FU = 4;

  // Class index doubles as the queue index
  typedef enum logic [1:0] {
    ARITH     = 2'd0,
    MUL       = 2'd1,
    DIV       = 2'd2,
    LOADSTORE = 2'd3
  } fu_class_e;

  // ALU operations carried in sub_op for the ARITH class
  typedef enum logic [3:0] {
    ADD  = 4'd0,
    SUB  = 4'd1,
    SLL  = 4'd2,
    SLT  = 4'd3,
    SLTU = 4'd4,
    XOR  = 4'd5,
    SRL  = 4'd6,
    SRA  = 4'd7,
    OR   = 4'd8,
    AND  = 4'd9
  } alu_op_e;

  // ALU op for ARITH, zero-extended funct3 for the other classes
  typedef logic [3:0] sub_op_t;

  // One bit per class, used for push, pop, full and empty
  typedef logic [NUM_FU-1:0] fu_vec_t;

endpackage

`default_nettype wire

/* rtl/decode_unit.sv */
// Decodes one fetched instruction at a time and pushes it into the queue of its class
`timescale 1ns/1ps
`default_nettype none

module decode_unit
  import rv32_isa_pkg::*;
  import dispatch_pkg::*;
(
  input  logic     CLK,
  input  logic     nRST,
  input  logic     fetch_req,
  input  word_t    fetch_instr,
  input  word_t    fetch_pc,
  output logic     fetch_ack,
  output reg_idx_t rs1_addr,
  output reg_idx_t rs2_addr,
  input  word_t    rs1_data,
  input  word_t    rs2_data,
  output fu_vec_t  push,
  input  fu_vec_t  q_full,
  output sub_op_t  sub_op,
  output reg_idx_t rd,
  output logic     wen,
  output word_t    op_a,
  output word_t    op_b,
  output word_t    store_data
);

  typedef enum logic {IDLE, WAIT_REQ_LOW} fetch_state_e;

  fetch_state_e state;
  opcode_t      opcode;
  funct3_t      funct3;
  funct7_t      funct7;
  word_t        imm_i;
  word_t        imm_s;
  word_t        imm_u;
  word_t        shamt;
  fu_class_e    fu_class;
  logic         valid;
  logic         accept;

  // funct3 to ALU op, shared by OP and OP_IMM
  function automatic alu_op_e alu_op_from(funct3_t f3, logic sub_sel, logic sra_sel);
    alu_op_e op;
    case (f3)
      3'd0:    op = sub_sel ? SUB : ADD;
      3'd1:    op = SLL;
      3'd2:    op = SLT;
      3'd3:    op = SLTU;
      3'd4:    op = XOR;
      3'd5:    op = sra_sel ? SRA : SRL;
      3'd6:    op = OR;
      default: op = AND;
    endcase
    return op;
  endfunction

  assign opcode   = fetch_instr[6:0];
  assign funct3   = fetch_instr[14:12];
  assign funct7   = fetch_instr[31:25];
  assign rs1_addr = fetch_instr[19:15];
  assign rs2_addr = fetch_instr[24:20];

  // Immediates
  assign imm_i = {{20{fetch_instr[31]}}, fetch_instr[31:20]};
  assign imm_s = {{20{fetch_instr[31]}}, fetch_instr[31:25], fetch_instr[11:7]};
  assign imm_u = {fetch_instr[31:12], 12'b0};
  assign shamt = {27'b0, fetch_instr[24:20]};

  // Class, sub-op and operand selection
  always_comb begin
    valid      = 1'b0;
    fu_class   = ARITH;
    sub_op     = sub_op_t'(ADD);
    rd         = fetch_instr[11:7];
    wen        = 1'b1;
    op_a       = rs1_data;
    op_b       = rs2_data;
    store_data = '0;
    case (opcode)
      OPC_OP: begin
        if (funct7 == FUNCT7_MULDIV) begin
          valid    = 1'b1;
          fu_class = funct3[2] ? DIV : MUL;
          sub_op   = {1'b0, funct3};
        end else if (funct7 == '0 || funct7 == FUNCT7_ALT) begin
          valid  = 1'b1;
          sub_op = sub_op_t'(alu_op_from(funct3, funct7 == FUNCT7_ALT,
                                         funct7 == FUNCT7_ALT));
        end
      end
      OPC_OP_IMM: begin
        valid  = 1'b1;
        // No SUBI, so funct7 only matters for right shifts
        sub_op = sub_op_t'(alu_op_from(funct3, 1'b0, funct7 == FUNCT7_ALT));
        op_b   = (funct3 == 3'd1 || funct3 == 3'd5) ? shamt : imm_i;
      end
      OPC_LUI: begin
        valid = 1'b1;
        op_a  = '0;
        op_b  = imm_u;
      end
      OPC_AUIPC: begin
        valid = 1'b1;
        op_a  = fetch_pc;
        op_b  = imm_u;
      end
      OPC_JAL: begin
        // Link value only, target is handled by fetch
        valid = 1'b1;
        op_a  = fetch_pc;
        op_b  = PC_STEP;
      end
      OPC_LOAD: begin
        valid    = 1'b1;
        fu_class = LOADSTORE;
        sub_op   = {1'b0, funct3};
        op_b     = imm_i;
      end
      OPC_STORE: begin
        valid      = 1'b1;
        fu_class   = LOADSTORE;
        sub_op     = {1'b0, funct3};
        rd         = '0;
        wen        = 1'b0;
        op_b       = imm_s;
        store_data = rs2_data;
      end
      default: begin
        wen = 1'b0;
      end
    endcase
  end

  // Unknown opcodes are accepted without waiting on any queue
  assign accept = fetch_req && state == IDLE && (!valid || !q_full[fu_class]);

  always_comb begin
    push           = '0;
    push[fu_class] = accept && valid;
  end

  // Fetch handshake
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      state <= IDLE;
    end else begin
      case (state)
        IDLE:         if (accept) state <= WAIT_REQ_LOW;
        WAIT_REQ_LOW: if (!fetch_req) state <= IDLE;
        default:      state <= IDLE;
      endcase
    end
  end

  assign fetch_ack = (state == WAIT_REQ_LOW);

endmodule

`default_nettype wire

/* rtl/fu_dispatch_queue.sv */
// Circular FIFO of decoded operations for one functional-unit class
`timescale 1ns/1ps
`default_nettype none

module fu_dispatch_queue
  import rv32_isa_pkg::*;
  import dispatch_pkg::*;
#(
  parameter int SLOT_DEPTH = 2
) (
  input  logic     CLK,
  input  logic     nRST,
  input  logic     push,
  input  sub_op_t  in_sub_op,
  input  reg_idx_t in_rd,
  input  logic     in_wen,
  input  word_t    in_op_a,
  input  word_t    in_op_b,
  input  word_t    in_store_data,
  output logic     full,
  output logic     empty,
  input  logic     pop,
  output sub_op_t  head_sub_op,
  output reg_idx_t head_rd,
  output logic     head_wen,
  output word_t    head_op_a,
  output word_t    head_op_b,
  output word_t    head_store_data
);

  localparam int PTR_W = (SLOT_DEPTH > 1) ? $clog2(SLOT_DEPTH) : 1;
  localparam int CNT_W = $clog2(SLOT_DEPTH + 1);
  localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(SLOT_DEPTH - 1);

  sub_op_t          sub_op_mem [SLOT_DEPTH];
  reg_idx_t         rd_mem     [SLOT_DEPTH];
  logic             wen_mem    [SLOT_DEPTH];
  word_t            op_a_mem   [SLOT_DEPTH];
  word_t            op_b_mem   [SLOT_DEPTH];
  word_t            store_mem  [SLOT_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             do_push;
  logic             do_pop;

  function automatic logic [PTR_W-1:0] next_ptr(logic [PTR_W-1:0] p);
    return (p == LAST_PTR) ? '0 : p + 1'b1;
  endfunction

  assign full    = (count == CNT_W'(SLOT_DEPTH));
  assign empty   = (count == '0);
  assign do_push = push && !full;
  assign do_pop  = pop && !empty;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) wr_ptr <= next_ptr(wr_ptr);
      if (do_pop) rd_ptr <= next_ptr(rd_ptr);
      // Count holds when both happen
      if (do_push && !do_pop) count <= count + 1'b1;
      else if (do_pop && !do_push) count <= count - 1'b1;
    end
  end

  always_ff @(posedge CLK) begin
    if (do_push) begin
      sub_op_mem[wr_ptr] <= in_sub_op;
      rd_mem[wr_ptr]     <= in_rd;
      wen_mem[wr_ptr]    <= in_wen;
      op_a_mem[wr_ptr]   <= in_op_a;
      op_b_mem[wr_ptr]   <= in_op_b;
      store_mem[wr_ptr]  <= in_store_data;
    end
  end

  // Oldest entry
  assign head_sub_op     = sub_op_mem[rd_ptr];
  assign head_rd         = rd_mem[rd_ptr];
  assign head_wen        = wen_mem[rd_ptr];
  assign head_op_a       = op_a_mem[rd_ptr];
  assign head_op_b       = op_b_mem[rd_ptr];
  assign head_store_data = store_mem[rd_ptr];

endmodule

`default_nettype wire

/* rtl/issue_arbiter.sv */
// Pops the lowest-index non-empty class queue and issues it to execute over a req/ack handshake
`timescale 1ns/1ps
`default_nettype none

module issue_arbiter
  import rv32_isa_pkg::*;
  import dispatch_pkg::*;
(
  input  logic      CLK,
  input  logic      nRST,
  input  fu_vec_t   q_empty,
  output fu_vec_t   pop,
  input  sub_op_t   head_sub_op     [NUM_FU],
  input  reg_idx_t  head_rd         [NUM_FU],
  input  logic      head_wen        [NUM_FU],
  input  word_t     head_op_a       [NUM_FU],
  input  word_t     head_op_b       [NUM_FU],
  input  word_t     head_store_data [NUM_FU],
  output logic      issue_req,
  output fu_class_e issue_class,
  output sub_op_t   issue_sub_op,
  output reg_idx_t  issue_rd,
  output logic      issue_wen,
  output word_t     issue_op_a,
  output word_t     issue_op_b,
  output word_t     issue_store_data,
  input  logic      issue_ack
);

  typedef enum logic [1:0] {IDLE, WAIT_ACK, WAIT_ACK_LOW} issue_state_e;

  issue_state_e state;
  fu_class_e    sel;
  logic         any_ready;
  logic         take;

  // Fixed priority, class 0 wins
  always_comb begin
    sel       = ARITH;
    any_ready = 1'b0;
    for (int i = NUM_FU - 1; i >= 0; i--) begin
      if (!q_empty[i]) begin
        sel       = fu_class_e'(i);
        any_ready = 1'b1;
      end
    end
  end

  assign take = (state == IDLE) && any_ready;

  always_comb begin
    pop      = '0;
    pop[sel] = take;
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      state <= IDLE;
    end else begin
      case (state)
        IDLE:         if (take) state <= WAIT_ACK;
        WAIT_ACK:     if (issue_ack) state <= WAIT_ACK_LOW;
        WAIT_ACK_LOW: if (!issue_ack) state <= IDLE;
        default:      state <= IDLE;
      endcase
    end
  end

  // Fields are captured with the pop and held for the whole handshake
  always_ff @(posedge CLK) begin
    if (take) begin
      issue_class      <= sel;
      issue_sub_op     <= head_sub_op[sel];
      issue_rd         <= head_rd[sel];
      issue_wen        <= head_wen[sel];
      issue_op_a       <= head_op_a[sel];
      issue_op_b       <= head_op_b[sel];
      issue_store_data <= head_store_data[sel];
    end
  end

  assign issue_req = (state == WAIT_ACK);

endmodule

`default_nettype wire

/* rtl/decode_dispatch_top.sv */
// Decode and dispatch front end, connecting the decoder, one queue per class and the issue arbiter
`timescale 1ns/1ps
`default_nettype none

module decode_dispatch_top
  import rv32_isa_pkg::*;
  import dispatch_pkg::*;
#(
  parameter int SLOT_DEPTH = 2
) (
  input  logic      CLK,
  input  logic      nRST,
  input  logic      fetch_req,
  input  word_t     fetch_instr,
  input  word_t     fetch_pc,
  output logic      fetch_ack,
  output reg_idx_t  rs1_addr,
  output reg_idx_t  rs2_addr,
  input  word_t     rs1_data,
  input  word_t     rs2_data,
  output logic      issue_req,
  output fu_class_e issue_class,
  output sub_op_t   issue_sub_op,
  output reg_idx_t  issue_rd,
  output logic      issue_wen,
  output word_t     issue_op_a,
  output word_t     issue_op_b,
  output word_t     issue_store_data,
  input  logic      issue_ack
);

  fu_vec_t  push;
  fu_vec_t  q_full;
  fu_vec_t  q_empty;
  fu_vec_t  pop;
  sub_op_t  dec_sub_op;
  reg_idx_t dec_rd;
  logic     dec_wen;
  word_t    dec_op_a;
  word_t    dec_op_b;
  word_t    dec_store_data;
  sub_op_t  q_sub_op     [NUM_FU];
  reg_idx_t q_rd         [NUM_FU];
  logic     q_wen        [NUM_FU];
  word_t    q_op_a       [NUM_FU];
  word_t    q_op_b       [NUM_FU];
  word_t    q_store_data [NUM_FU];

  decode_unit decode_i (
    .CLK        (CLK),
    .nRST       (nRST),
    .fetch_req  (fetch_req),
    .fetch_instr(fetch_instr),
    .fetch_pc   (fetch_pc),
    .fetch_ack  (fetch_ack),
    .rs1_addr   (rs1_addr),
    .rs2_addr   (rs2_addr),
    .rs1_data   (rs1_data),
    .rs2_data   (rs2_data),
    .push       (push),
    .q_full     (q_full),
    .sub_op     (dec_sub_op),
    .rd         (dec_rd),
    .wen        (dec_wen),
    .op_a       (dec_op_a),
    .op_b       (dec_op_b),
    .store_data (dec_store_data)
  );

  // One queue per class, indexed by fu_class_e
  for (genvar g = 0; g < NUM_FU; g++) begin : g_queue
    fu_dispatch_queue #(
      .SLOT_DEPTH(SLOT_DEPTH)
    ) queue_i (
      .CLK            (CLK),
      .nRST           (nRST),
      .push           (push[g]),
      .in_sub_op      (dec_sub_op),
      .in_rd          (dec_rd),
      .in_wen         (dec_wen),
      .in_op_a        (dec_op_a),
      .in_op_b        (dec_op_b),
      .in_store_data  (dec_store_data),
      .full           (q_full[g]),
      .empty          (q_empty[g]),
      .pop            (pop[g]),
      .head_sub_op    (q_sub_op[g]),
      .head_rd        (q_rd[g]),
      .head_wen       (q_wen[g]),
      .head_op_a      (q_op_a[g]),
      .head_op_b      (q_op_b[g]),
      .head_store_data(q_store_data[g])
    );
  end

  issue_arbiter arbiter_i (
    .CLK             (CLK),
    .nRST            (nRST),
    .q_empty         (q_empty),
    .pop             (pop),
    .head_sub_op     (q_sub_op),
    .head_rd         (q_rd),
    .head_wen        (q_wen),
    .head_op_a       (q_op_a),
    .head_op_b       (q_op_b),
    .head_store_data (q_store_data),
    .issue_req       (issue_req),
    .issue_class     (issue_class),
    .issue_sub_op    (issue_sub_op),
    .issue_rd        (issue_rd),
    .issue_wen       (issue_wen),
    .issue_op_a      (issue_op_a),
    .issue_op_b      (issue_op_b),
    .issue_store_data(issue_store_data),
    .issue_ack       (issue_ack)
  );

endmodule

`default_nettype wire

/* testbench/decode_dispatch_vectors.svh */
// Stimulus table for the decode and dispatch testbench, included in its module body
`ifndef DECODE_DISPATCH_VECTORS_SVH
`define DECODE_DISPATCH_VECTORS_SVH

  // Columns: name, instr, pc, valid, class, sub_op, rd, wen, op_a, op_b, store_data
  // Register file model returns index * 0x01010101
  task automatic load_vectors();
    // R-type ALU
    add_row("add x3,x1,x2", 32'h002081B3, 32'h00001000, 1'b1, ARITH, ADD, 5'd3,
            1'b1, 32'h01010101, 32'h02020202, 32'h00000000);
    add_row("sub x4,x5,x6", 32'h40628233, 32'h00001004, 1'b1, ARITH, SUB, 5'd4,
            1'b1, 32'h05050505, 32'h06060606, 32'h00000000);
    add_row("sra x7,x8,x9", 32'h409453B3, 32'h00001008, 1'b1, ARITH, SRA, 5'd7,
            1'b1, 32'h08080808, 32'h09090909, 32'h00000000);
    add_row("sltu x10,x11,x12", 32'h00C5B533, 32'h0000100C, 1'b1, ARITH, SLTU, 5'd10,
            1'b1, 32'h0B0B0B0B, 32'h0C0C0C0C, 32'h00000000);
    // I-type ALU, shifts take shamt
    add_row("addi x1,x2,-5", 32'hFFB10093, 32'h00001010, 1'b1, ARITH, ADD, 5'd1,
            1'b1, 32'h02020202, 32'hFFFFFFFB, 32'h00000000);
    add_row("slli x5,x6,7", 32'h00731293, 32'h00001014, 1'b1, ARITH, SLL, 5'd5,
            1'b1, 32'h06060606, 32'h00000007, 32'h00000000);
    add_row("srai x9,x10,31", 32'h41F55493, 32'h00001018, 1'b1, ARITH, SRA, 5'd9,
            1'b1, 32'h0A0A0A0A, 32'h0000001F, 32'h00000000);
    add_row("xori x12,x13,0x7ff", 32'h7FF6C613, 32'h0000101C, 1'b1, ARITH, XOR, 5'd12,
            1'b1, 32'h0D0D0D0D, 32'h000007FF, 32'h00000000);
    // Upper immediates and link
    add_row("lui x14", 32'hABCDE737, 32'h00001020, 1'b1, ARITH, ADD, 5'd14,
            1'b1, 32'h00000000, 32'hABCDE000, 32'h00000000);
    add_row("auipc x15", 32'h12345797, 32'h00001024, 1'b1, ARITH, ADD, 5'd15,
            1'b1, 32'h00001024, 32'h12345000, 32'h00000000);
    add_row("jal x1", 32'h008000EF, 32'h00001028, 1'b1, ARITH, ADD, 5'd1,
            1'b1, 32'h00001028, 32'h00000004, 32'h00000000);
    // Loads and stores
    add_row("lw x16,-4(x17)", 32'hFFC8A803, 32'h0000102C, 1'b1, LOADSTORE, 4'd2, 5'd16,
            1'b1, 32'h11111111, 32'hFFFFFFFC, 32'h00000000);
    add_row("sw x19,20(x18)", 32'h01392A23, 32'h00001030, 1'b1, LOADSTORE, 4'd2, 5'd0,
            1'b0, 32'h12121212, 32'h00000014, 32'h13131313);
    add_row("sb x20,-1(x21)", 32'hFF4A8FA3, 32'h00001034, 1'b1, LOADSTORE, 4'd0, 5'd0,
            1'b0, 32'h15151515, 32'hFFFFFFFF, 32'h14141414);
    add_row("unknown 0x7f", 32'hFFFFFFFF, 32'h00001038, 1'b0, ARITH, 4'd0, 5'd0,
            1'b0, 32'h00000000, 32'h00000000, 32'h00000000);
    // Back-to-back multiply and divide
    add_row("mul x3,x4,x5", 32'h025201B3, 32'h0000103C, 1'b1, MUL, 4'd0, 5'd3,
            1'b1, 32'h04040404, 32'h05050505, 32'h00000000);
    add_row("mulhu x6,x7,x8", 32'h0283B333, 32'h00001040, 1'b1, MUL, 4'd3, 5'd6,
            1'b1, 32'h07070707, 32'h08080808, 32'h00000000);
    add_row("div x9,x10,x11", 32'h02B544B3, 32'h00001044, 1'b1, DIV, 4'd4, 5'd9,
            1'b1, 32'h0A0A0A0A, 32'h0B0B0B0B, 32'h00000000);
    add_row("remu x12,x13,x14", 32'h02E6F633, 32'h00001048, 1'b1, DIV, 4'd7, 5'd12,
            1'b1, 32'h0D0D0D0D, 32'h0E0E0E0E, 32'h00000000);
    add_row("mul x1,x2,x3", 32'h023100B3, 32'h0000104C, 1'b1, MUL, 4'd0, 5'd1,
            1'b1, 32'h02020202, 32'h03030303, 32'h00000000);
    add_row("divu x2,x3,x4", 32'h0241D133, 32'h00001050, 1'b1, DIV, 4'd5, 5'd2,
            1'b1, 32'h03030303, 32'h04040404, 32'h00000000);
    add_row("mulh x5,x6,x7", 32'h027312B3, 32'h00001054, 1'b1, MUL, 4'd1, 5'd5,
            1'b1, 32'h06060606, 32'h07070707, 32'h00000000);
    add_row("fence", 32'h0FF0000F, 32'h00001058, 1'b0, ARITH, 4'd0, 5'd0,
            1'b0, 32'h00000000, 32'h00000000, 32'h00000000);
    add_row("and x20,x21,x22", 32'h016AFA33, 32'h0000105C, 1'b1, ARITH, AND, 5'd20,
            1'b1, 32'h15151515, 32'h16161616, 32'h00000000);
    add_row("lbu x25,0x7f0(x26)", 32'h7F0D4C83, 32'h00001060, 1'b1, LOADSTORE, 4'd4, 5'd25,
            1'b1, 32'h1A1A1A1A, 32'h000007F0, 32'h00000000);
  endtask

`endif

/* testbench/tb_decode_dispatch.sv */
// Self-checking testbench for the decode and dispatch front end, built from filelist.f
`timescale 1ns/1ps
`default_nettype none

module tb_decode_dispatch
  import rv32_isa_pkg::*;
  import dispatch_pkg::*;
();

  localparam int MAX_ROWS       = 32;
  localparam int TIMEOUT_CYCLES = 200;

  logic      CLK;
  logic      nRST;
  logic      fetch_req;
  word_t     fetch_instr;
  word_t     fetch_pc;
  logic      fetch_ack;
  reg_idx_t  rs1_addr;
  reg_idx_t  rs2_addr;
  word_t     rs1_data;
  word_t     rs2_data;
  logic      issue_req;
  fu_class_e issue_class;
  sub_op_t   issue_sub_op;
  reg_idx_t  issue_rd;
  logic      issue_wen;
  word_t     issue_op_a;
  word_t     issue_op_b;
  word_t     issue_store_data;
  logic      issue_ack;

  // Stimulus table
  string     vec_name   [MAX_ROWS];
  word_t     vec_instr  [MAX_ROWS];
  word_t     vec_pc     [MAX_ROWS];
  logic      vec_valid  [MAX_ROWS];
  fu_class_e vec_class  [MAX_ROWS];
  sub_op_t   vec_sub_op [MAX_ROWS];
  reg_idx_t  vec_rd     [MAX_ROWS];
  logic      vec_wen    [MAX_ROWS];
  word_t     vec_op_a   [MAX_ROWS];
  word_t     vec_op_b   [MAX_ROWS];
  word_t     vec_store  [MAX_ROWS];
  int        num_rows;
  int        num_valid;

  // Row indices still to issue, oldest first per class
  int        expected_q [NUM_FU][$];
  int        issued;
  int        seed;

  decode_dispatch_top #(
    .SLOT_DEPTH(2)
  ) dut_i (
    .CLK             (CLK),
    .nRST            (nRST),
    .fetch_req       (fetch_req),
    .fetch_instr     (fetch_instr),
    .fetch_pc        (fetch_pc),
    .fetch_ack       (fetch_ack),
    .rs1_addr        (rs1_addr),
    .rs2_addr        (rs2_addr),
    .rs1_data        (rs1_data),
    .rs2_data        (rs2_data),
    .issue_req       (issue_req),
    .issue_class     (issue_class),
    .issue_sub_op    (issue_sub_op),
    .issue_rd        (issue_rd),
    .issue_wen       (issue_wen),
    .issue_op_a      (issue_op_a),
    .issue_op_b      (issue_op_b),
    .issue_store_data(issue_store_data),
    .issue_ack       (issue_ack)
  );

  // Register file model
  assign rs1_data = {27'b0, rs1_addr} * 32'h01010101;
  assign rs2_data = {27'b0, rs2_addr} * 32'h01010101;

  initial begin
    CLK = 1'b0;
    forever #10 CLK = ~CLK;
  end

  `include "decode_dispatch_vectors.svh"

  task automatic stop_with_error(string msg);
    $display("%s", msg);
    $display("Test failed");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic add_row(string name, word_t instr, word_t pc, logic valid, fu_class_e cls,
                         sub_op_t sub_op, reg_idx_t rd, logic wen, word_t op_a, word_t op_b,
                         word_t store_data);
    if (num_rows >= MAX_ROWS) begin
      stop_with_error("Stimulus table has more rows than the testbench can hold");
    end
    vec_name[num_rows]   = name;
    vec_instr[num_rows]  = instr;
    vec_pc[num_rows]     = pc;
    vec_valid[num_rows]  = valid;
    vec_class[num_rows]  = cls;
    vec_sub_op[num_rows] = sub_op;
    vec_rd[num_rows]     = rd;
    vec_wen[num_rows]    = wen;
    vec_op_a[num_rows]   = op_a;
    vec_op_b[num_rows]   = op_b;
    vec_store[num_rows]  = store_data;
    if (valid) num_valid++;
    num_rows++;
  endtask

  task automatic compare_class(string name, fu_class_e exp, fu_class_e act);
    if (act !== exp) begin
      stop_with_error($sformatf("[ERROR] %s expected %s actual %s", name, exp.name(),
                                act.name()));
    end
  endtask

  task automatic compare_sub_op(string name, sub_op_t exp, sub_op_t act);
    if (act !== exp) begin
      stop_with_error($sformatf("[ERROR] %s expected %0d actual %0d", name, exp, act));
    end
  endtask

  task automatic compare_reg(string name, reg_idx_t exp, reg_idx_t act);
    if (act !== exp) begin
      stop_with_error($sformatf("[ERROR] %s expected x%0d actual x%0d", name, exp, act));
    end
  endtask

  task automatic compare_word(string name, word_t exp, word_t act);
    if (act !== exp) begin
      stop_with_error($sformatf("[ERROR] %s expected 0x%08h actual 0x%08h", name, exp, act));
    end
  endtask

  task automatic compare_bit(string name, logic exp, logic act);
    if (act !== exp) begin
      stop_with_error($sformatf("[ERROR] %s expected %b actual %b", name, exp, act));
    end
  endtask

  task automatic wait_fetch_ack(logic level);
    int cycles;
    cycles = 0;
    do begin
      @(negedge CLK);
      cycles++;
      if (cycles > TIMEOUT_CYCLES) begin
        stop_with_error($sformatf("Timed out waiting for fetch_ack to go %b", level));
      end
    end while (fetch_ack !== level);
  endtask

  task automatic wait_issue_req(logic level);
    int cycles;
    cycles = 0;
    do begin
      @(negedge CLK);
      cycles++;
      if (cycles > TIMEOUT_CYCLES) begin
        stop_with_error($sformatf("Timed out waiting for issue_req to go %b", level));
      end
    end while (issue_req !== level);
  endtask

  // One four-phase fetch transfer
  task automatic send_row(int r);
    @(posedge CLK);
    fetch_req   <= 1'b1;
    fetch_instr <= vec_instr[r];
    fetch_pc    <= vec_pc[r];
    if (vec_valid[r]) expected_q[int'(vec_class[r])].push_back(r);
    wait_fetch_ack(1'b1);
    @(posedge CLK);
    fetch_req <= 1'b0;
    wait_fetch_ack(1'b0);
  endtask

  task automatic send_all();
    for (int r = 0; r < num_rows; r++) begin
      send_row(r);
    end
  endtask

  // Class whose oldest pending row carries the issued fields
  function automatic int matching_class(fu_class_e fallback);
    int found;
    int r;
    found = int'(fallback);
    for (int c = 0; c < NUM_FU; c++) begin
      if (expected_q[c].size() != 0) begin
        r = expected_q[c][0];
        if (vec_sub_op[r] == issue_sub_op && vec_rd[r] == issue_rd &&
            vec_op_a[r] == issue_op_a && vec_op_b[r] == issue_op_b) begin
          found = c;
        end
      end
    end
    return found;
  endfunction

  // Match one issued operation, then acknowledge after a random delay
  task automatic receive_one();
    int        row;
    int        delay;
    string     name;
    fu_class_e cls;
    wait_issue_req(1'b1);
    cls = fu_class_e'(matching_class(issue_class));
    if (expected_q[int'(cls)].size() == 0) begin
      stop_with_error($sformatf("Operation issued on class %s with none pending there",
                                cls.name()));
    end
    row  = expected_q[int'(cls)].pop_front();
    name = vec_name[row];
    compare_class({name, " class"}, vec_class[row], issue_class);
    compare_sub_op({name, " sub_op"}, vec_sub_op[row], issue_sub_op);
    compare_reg({name, " rd"}, vec_rd[row], issue_rd);
    compare_bit({name, " wen"}, vec_wen[row], issue_wen);
    compare_word({name, " op_a"}, vec_op_a[row], issue_op_a);
    compare_word({name, " op_b"}, vec_op_b[row], issue_op_b);
    compare_word({name, " store_data"}, vec_store[row], issue_store_data);
    issued++;
    // Slow execute side fills the queues
    delay = $random(seed) & 7;
    repeat (delay) @(posedge CLK);
    @(posedge CLK);
    issue_ack <= 1'b1;
    wait_issue_req(1'b0);
    @(posedge CLK);
    issue_ack <= 1'b0;
  endtask

  task automatic receive_all();
    while (issued < num_valid) begin
      receive_one();
    end
  endtask

  initial begin
    seed        = 36;
    nRST        = 1'b0;
    fetch_req   = 1'b0;
    fetch_instr = '0;
    fetch_pc    = '0;
    issue_ack   = 1'b0;
    issued      = 0;
    num_rows    = 0;
    num_valid   = 0;
    load_vectors();

    repeat (5) @(posedge CLK);
    nRST <= 1'b1;

    // Quiet after reset, nothing fetched yet
    repeat (4) begin
      @(negedge CLK);
      compare_bit("reset fetch_ack", 1'b0, fetch_ack);
      compare_bit("reset issue_req", 1'b0, issue_req);
    end

    fork
      send_all();
      receive_all();
    join

    // Unknown opcodes must never show up
    repeat (40) begin
      @(negedge CLK);
      compare_bit("drain issue_req", 1'b0, issue_req);
    end

    $display("Issued %0d of %0d rows", issued, num_rows);
    $display("Test passed");
    $finish;
  end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+testbench
rtl/rv32_isa_pkg.sv
rtl/dispatch_pkg.sv
rtl/decode_unit.sv
rtl/fu_dispatch_queue.sv
rtl/issue_arbiter.sv
rtl/decode_dispatch_top.sv
testbench/tb_decode_dispatch.sv

/* run_sim.sh */
#!/bin/sh
# Builds the decode/dispatch testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f filelist.f --top-module tb_decode_dispatch -o tb_sim
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

output=$(./obj_dir/tb_sim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qx "Test passed"; then
  exit 0
else
  echo "Pass message not found in simulation output"
  exit 1
fi
